//--- Makefile
# Verilator build and run of the diagonal pixel buffer testbench

SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := diagonal_buffer_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
PASS_TEXT := ** PASS **

BIN := $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove the $(BUILD_DIR) build directory"
	@echo "  help   list these targets"

# the run passes only when the testbench prints the pass message
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/diag_buffer_model.svh
// reference model helpers and stimulus table for the diagonal buffer testbench
`ifndef DIAG_BUFFER_MODEL_SVH
`define DIAG_BUFFER_MODEL_SVH

localparam int ROWS = 40;
localparam int HALF_NARROW = diag_buffer_pkg::NARROW_LANES / 2;

typedef logic signed [pixel_pkg::NARROW_WIDTH-1:0] narrow_t;
typedef logic signed [pixel_pkg::WIDE_WIDTH-1:0] wide_t;

// hand-picked values around zero, the pixel max and the sample limits
localparam int NARROW_EDGES [8] = '{-512, -1, 0, 1, 128, 255, 256, 511};
localparam int WIDE_EDGES [9] = '{-1024, -1, 0, 254, 255, 256, 511, 512, 1023};

// one row per cycle: narrow samples, wide samples, enable
narrow_t narrow_tbl [ROWS][diag_buffer_pkg::NARROW_LANES];
wide_t wide_tbl [ROWS][diag_buffer_pkg::WIDE_LANES];
logic enable_tbl [ROWS];

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// model rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic pixel_pkg::pixel_t saturate(input int value);
	int top;
	top = (1 << pixel_pkg::PIXEL_WIDTH) - 1;
	if (value < 0)
		return '0;
	if (value > top)
		return pixel_pkg::pixel_t'(top);
	return pixel_pkg::pixel_t'(value);
endfunction

// output lanes 9..17 come from the wide group
function automatic bit is_wide_lane(input int lane);
	return (lane >= HALF_NARROW) && (lane < HALF_NARROW + diag_buffer_pkg::WIDE_LANES);
endfunction

function automatic int source_lane(input int lane);
	if (lane < HALF_NARROW)
		return lane;
	if (is_wide_lane(lane))
		return lane - HALF_NARROW;
	return lane - diag_buffer_pkg::WIDE_LANES;   // narrow 9 up
endfunction

// idle start, long enabled runs, a freeze, a one-cycle gap, then a ragged tail
function automatic logic row_enable(input int r);
	if (r < 3 || (r >= 16 && r < 20) || r == 24)
		return 1'b0;
	if (r >= 36)
		return (r % 3) != 0;
	return 1'b1;
endfunction

task automatic build_table();
	for (int r = 0; r < ROWS; r++) begin
		for (int i = 0; i < diag_buffer_pkg::NARROW_LANES; i++) begin
			if (r < 4)
				narrow_tbl[r][i] = narrow_t'(i + 1);   // lane map
			else if (r < 8)
				narrow_tbl[r][i] = narrow_t'(NARROW_EDGES[(i + r) % 8]);
			else if (r < 25)
				narrow_tbl[r][i] = narrow_t'((r * 18 + i) % 256);
			else
				narrow_tbl[r][i] = narrow_t'($urandom);
		end
		for (int j = 0; j < diag_buffer_pkg::WIDE_LANES; j++) begin
			if (r < 4)
				wide_tbl[r][j] = wide_t'(200 + j);
			else if (r < 8)
				wide_tbl[r][j] = wide_t'(WIDE_EDGES[(j + r) % 9]);
			else if (r < 25)
				wide_tbl[r][j] = wide_t'((r * 11 + j * 3 + 50) % 256);
			else
				wide_tbl[r][j] = wide_t'($urandom);
		end
		enable_tbl[r] = row_enable(r);
	end
endtask

`endif

//--- dv/diagonal_buffer_tb.sv
// testbench for the diagonal pixel buffer, table driven against a cycle model
`timescale 1ns/1ps

module diagonal_buffer_tb;

	localparam int PW = pixel_pkg::PIXEL_WIDTH;
	localparam int NW = pixel_pkg::NARROW_WIDTH;
	localparam int WW = pixel_pkg::WIDE_WIDTH;
	localparam int NL = diag_buffer_pkg::NARROW_LANES;
	localparam int WL = diag_buffer_pkg::WIDE_LANES;
	localparam int LANES = diag_buffer_pkg::LANES;
	localparam int DEPTH = diag_buffer_pkg::DELAY_DEPTH;
	localparam int LATENCY = DEPTH + 1;
	localparam int RESET_CYCLES = 5;
	localparam int CLOCK_PERIOD = 20;
	localparam bit [31:0] RANDOM_SEED = 32'h264cff40;

	logic clock;
	logic rst;
	logic enable;
	logic signed [NL-1:0][NW-1:0] narrow_samples;
	logic signed [WL-1:0][WW-1:0] wide_samples;
	logic [LANES-1:0][PW-1:0] pixels;

	`include "diag_buffer_model.svh"

	localparam int CYCLE_LIMIT = 2 * (ROWS + RESET_CYCLES + DEPTH);

	// model state mirrors the saturation register and the delay stages
	pixel_pkg::pixel_t sat_model [LANES];
	pixel_pkg::pixel_t stage_model [DEPTH][LANES];

	int errors;
	int checks;
	int cycle_count;

	diagonal_buffer #(
		.PIXEL_WIDTH(PW),
		.NARROW_WIDTH(NW),
		.WIDE_WIDTH(WW),
		.NARROW_LANES(NL),
		.WIDE_LANES(WL),
		.DEPTH(DEPTH)
	) diagonal_buffer_i (
		.clock(clock),
		.rst(rst),
		.enable(enable),
		.narrow_samples(narrow_samples),
		.wide_samples(wide_samples),
		.pixels(pixels)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// clock and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count > CYCLE_LIMIT) begin
				$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
				$display("** FAIL **");
				$finish;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// model, drive, check
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// called at the rising edge with the inputs the DUT just sampled
	task automatic model_step();
		int value;
		int src;
		if (rst) begin
			sat_model = '{default: '0};
			stage_model = '{default: '0};
		end else begin
			if (enable) begin
				for (int s = DEPTH - 1; s > 0; s--)
					stage_model[s] = stage_model[s-1];
				stage_model[0] = sat_model;
			end
			for (int lane = 0; lane < LANES; lane++) begin
				src = source_lane(lane);
				if (is_wide_lane(lane))
					value = int'($signed(wide_samples[src]));
				else
					value = int'($signed(narrow_samples[src]));
				sat_model[lane] = saturate(value);   // saturator ignores enable
			end
		end
	endtask

	task automatic drive_row(input int r);
		logic signed [NL-1:0][NW-1:0] n_vec;
		logic signed [WL-1:0][WW-1:0] w_vec;
		n_vec = '0;
		w_vec = '0;
		if (r < ROWS) begin
			for (int i = 0; i < NL; i++)
				n_vec[i] = narrow_tbl[r][i];
			for (int j = 0; j < WL; j++)
				w_vec[j] = wide_tbl[r][j];
			enable <= enable_tbl[r];
		end else begin
			enable <= 1'b1;   // drain
		end
		narrow_samples <= n_vec;
		wide_samples <= w_vec;
	endtask

	task automatic check_pixels();
		pixel_pkg::pixel_t expected;
		for (int lane = 0; lane < LANES; lane++) begin
			expected = stage_model[DEPTH-1][lane];
			checks++;
			assert (pixels[lane] === expected) else begin
				errors++;
				$display("FAILED at %0t ns: pixels[%0d] expected %0d, actual %0d",
					$time, lane, expected, pixels[lane]);
			end
		end
	endtask

	initial begin
		void'($urandom(RANDOM_SEED));
		rst = 1'b1;
		enable = 1'b0;
		narrow_samples = '0;
		wide_samples = '0;
		errors = 0;
		checks = 0;
		sat_model = '{default: '0};
		stage_model = '{default: '0};
		build_table();

		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge clock);
			model_step();
			if (c == RESET_CYCLES - 1)
				rst <= 1'b0;
			@(negedge clock);
			check_pixels();
		end

		// table rows, then enough enabled cycles to flush the line
		for (int r = 0; r < ROWS + LATENCY; r++) begin
			@(posedge clock);
			model_step();
			drive_row(r);
			@(negedge clock);
			check_pixels();
		end

		$display("diagonal_buffer_tb: %0d errors in %0d lane checks", errors, checks);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- hw/diag_buffer_pkg.sv
// lane counts and delay depth of the diagonal pixel buffer
package diag_buffer_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lane geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int NARROW_LANES = 18;   // split in two halves around the wide group
	localparam int WIDE_LANES = 9;

	localparam int LANES = NARROW_LANES + WIDE_LANES;

	// first output lane of each group
	localparam int WIDE_FIRST_LANE = NARROW_LANES / 2;
	localparam int NARROW_HIGH_FIRST_LANE = WIDE_FIRST_LANE + WIDE_LANES;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// delay
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// enable-gated stages after the saturation register
	localparam int DELAY_DEPTH = 9;

	// cycles from sample to pixel with enable held high
	localparam int LATENCY = DELAY_DEPTH + 1;

endpackage

//--- hw/diagonal_buffer.sv
// diagonal pixel buffer top, saturates 27 signed lanes and delays them in reference order
`timescale 1ns/1ps

module diagonal_buffer #(
	parameter int PIXEL_WIDTH = pixel_pkg::PIXEL_WIDTH,
	parameter int NARROW_WIDTH = pixel_pkg::NARROW_WIDTH,
	parameter int WIDE_WIDTH = pixel_pkg::WIDE_WIDTH,
	parameter int NARROW_LANES = diag_buffer_pkg::NARROW_LANES,
	parameter int WIDE_LANES = diag_buffer_pkg::WIDE_LANES,
	parameter int DEPTH = diag_buffer_pkg::DELAY_DEPTH
) (
	input logic clock,
	input logic rst,
	input logic enable,
	input logic signed [NARROW_LANES-1:0][NARROW_WIDTH-1:0] narrow_samples,
	input logic signed [WIDE_LANES-1:0][WIDE_WIDTH-1:0] wide_samples,
	output logic [NARROW_LANES+WIDE_LANES-1:0][PIXEL_WIDTH-1:0] pixels
);

	localparam int LANES = NARROW_LANES + WIDE_LANES;

	// narrow lanes below this index sit ahead of the wide group
	localparam int SPLIT = NARROW_LANES / 2;

	logic [NARROW_LANES-1:0][PIXEL_WIDTH-1:0] narrow_pix;
	logic [WIDE_LANES-1:0][PIXEL_WIDTH-1:0] wide_pix;
	logic [LANES-1:0][PIXEL_WIDTH-1:0] ordered;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// saturation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pixel_saturate #(
		.SAMPLE_WIDTH(NARROW_WIDTH),
		.PIXEL_WIDTH(PIXEL_WIDTH),
		.GROUP_LANES(NARROW_LANES)
	) narrow_sat (
		.clock(clock),
		.rst(rst),
		.samples(narrow_samples),
		.pixels(narrow_pix)
	);

	pixel_saturate #(
		.SAMPLE_WIDTH(WIDE_WIDTH),
		.PIXEL_WIDTH(PIXEL_WIDTH),
		.GROUP_LANES(WIDE_LANES)
	) wide_sat (
		.clock(clock),
		.rst(rst),
		.samples(wide_samples),
		.pixels(wide_pix)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lane order
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// low narrow half, then the wide group, then the high narrow half
	for (genvar lane = 0; lane < LANES; lane++) begin : g_order
		if (lane < SPLIT) begin : g_narrow_low
			assign ordered[lane] = narrow_pix[lane];
		end else if (lane < SPLIT + WIDE_LANES) begin : g_wide
			assign ordered[lane] = wide_pix[lane - SPLIT];
		end else begin : g_narrow_high
			assign ordered[lane] = narrow_pix[lane - WIDE_LANES];   // narrow 9 up
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// delay
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one saturation cycle plus DEPTH enabled shifts end to end
	diagonal_delay_line #(
		.LANES(LANES),
		.DEPTH(DEPTH),
		.PIXEL_WIDTH(PIXEL_WIDTH)
	) delay (
		.clock(clock),
		.rst(rst),
		.enable(enable),
		.pixel_in(ordered),
		.pixel_out(pixels)
	);

endmodule

//--- hw/diagonal_delay_line.sv
// enable-gated multi-stage pixel delay, one shift register per lane
`timescale 1ns/1ps

module diagonal_delay_line #(
	parameter int LANES = diag_buffer_pkg::LANES,
	parameter int DEPTH = diag_buffer_pkg::DELAY_DEPTH,
	parameter int PIXEL_WIDTH = pixel_pkg::PIXEL_WIDTH
) (
	input logic clock,
	input logic rst,
	input logic enable,
	input logic [LANES-1:0][PIXEL_WIDTH-1:0] pixel_in,
	output logic [LANES-1:0][PIXEL_WIDTH-1:0] pixel_out
);

	if (DEPTH < 1) begin : g_depth_check
		$error("diagonal_delay_line: DEPTH must be at least 1, got %0d", DEPTH);
	end

	if (LANES < 1) begin : g_lane_check
		$error("diagonal_delay_line: LANES must be at least 1, got %0d", LANES);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// stage 0 takes pixel_in, stage DEPTH-1 drives the output
	logic [DEPTH-1:0][LANES-1:0][PIXEL_WIDTH-1:0] stage;

	// all lanes shift together, nothing moves while enable is low
	always_ff @(posedge clock) begin
		if (rst) begin
			stage <= '0;
		end else if (enable) begin
			stage[0] <= pixel_in;
			for (int s = 1; s < DEPTH; s++) begin
				stage[s] <= stage[s-1];
			end
		end
	end

	assign pixel_out = stage[DEPTH-1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a held line keeps its output across the edge
	assert property (
		@(posedge clock)
		(!rst && !enable) |=> $stable(pixel_out)
	) else begin
		$error("diagonal_delay_line: output moved while enable was low");
	end

	// output reads zero after a reset edge
	assert property (
		@(posedge clock)
		rst |=> (pixel_out == '0)
	) else begin
		$error("diagonal_delay_line: output not zero after reset");
	end

endmodule

//--- hw/pixel_pkg.sv
// pixel and sample widths for the saturation datapath, with the pixel limits
package pixel_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output pixel
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int PIXEL_WIDTH = 8;

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;

	localparam pixel_t PIXEL_MIN = '0;   // floor for negative samples
	localparam pixel_t PIXEL_MAX = '1;   // ceiling for overflowed samples

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// signed input samples
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one extra magnitude bit plus sign
	localparam int NARROW_WIDTH = PIXEL_WIDTH + 2;
	// two extra magnitude bits plus sign
	localparam int WIDE_WIDTH = PIXEL_WIDTH + 3;

	// full signed range of each sample width
	localparam int NARROW_SAMPLE_MIN = -(2 ** (NARROW_WIDTH - 1));
	localparam int NARROW_SAMPLE_MAX = (2 ** (NARROW_WIDTH - 1)) - 1;
	localparam int WIDE_SAMPLE_MIN = -(2 ** (WIDE_WIDTH - 1));
	localparam int WIDE_SAMPLE_MAX = (2 ** (WIDE_WIDTH - 1)) - 1;

endpackage

//--- hw/pixel_saturate.sv
// registered clamp of a group of signed samples to unsigned pixels
`timescale 1ns/1ps

module pixel_saturate #(
	parameter int SAMPLE_WIDTH = pixel_pkg::NARROW_WIDTH,
	parameter int PIXEL_WIDTH = pixel_pkg::PIXEL_WIDTH,
	parameter int GROUP_LANES = diag_buffer_pkg::WIDE_LANES
) (
	input logic clock,
	input logic rst,
	input logic signed [GROUP_LANES-1:0][SAMPLE_WIDTH-1:0] samples,
	output logic [GROUP_LANES-1:0][PIXEL_WIDTH-1:0] pixels
);

	localparam int SIGN_BIT = SAMPLE_WIDTH - 1;

	// sample needs at least sign plus one bit above the pixel range
	if (SAMPLE_WIDTH < PIXEL_WIDTH + 2) begin : g_width_check
		$error("pixel_saturate: SAMPLE_WIDTH %0d too narrow for PIXEL_WIDTH %0d",
			SAMPLE_WIDTH, PIXEL_WIDTH);
	end

	logic [GROUP_LANES-1:0] negative;
	logic [GROUP_LANES-1:0] overflow;
	logic [GROUP_LANES-1:0][PIXEL_WIDTH-1:0] clamped;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-lane classify
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// every magnitude bit above the pixel counts, wide lanes included
	always_comb begin
		for (int lane = 0; lane < GROUP_LANES; lane++) begin
			negative[lane] = samples[lane][SIGN_BIT];
			overflow[lane] = |samples[lane][SIGN_BIT-1:PIXEL_WIDTH];
		end
	end

	always_comb begin
		for (int lane = 0; lane < GROUP_LANES; lane++) begin
			if (negative[lane]) begin
				clamped[lane] = '0;
			end else if (overflow[lane]) begin
				clamped[lane] = '1;   // above max
			end else begin
				clamped[lane] = samples[lane][PIXEL_WIDTH-1:0];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// runs every cycle, enable only gates the delay line
	always_ff @(posedge clock) begin
		if (rst) begin
			pixels <= '0;
		end else begin
			pixels <= clamped;
		end
	end

	// a negative sample lands as a zero pixel on the next edge
	for (genvar lane = 0; lane < GROUP_LANES; lane++) begin : g_neg_check
		assert property (
			@(posedge clock) disable iff (rst)
			samples[lane][SIGN_BIT] |=> (pixels[lane] == '0)
		) else begin
			$error("pixel_saturate: lane %0d negative sample not clamped to zero", lane);
		end
	end

endmodule

//--- sources.f
+incdir+dv
hw/pixel_pkg.sv
hw/diag_buffer_pkg.sv
hw/pixel_saturate.sv
hw/diagonal_delay_line.sv
hw/diagonal_buffer.sv
dv/diagonal_buffer_tb.sv
